// ==== design/sram_pkg.sv ====
package sram_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int BYTE_W = DATA_W / STRB_W;

  localparam int MEM_WORDS_LOG2 = 10;
  localparam int MEM_WORDS = 1 << MEM_WORDS_LOG2;

  // Latency is LAT_MIN plus the low LAT_BITS of the LFSR.
  localparam int LAT_BITS = 4;
  localparam int LAT_MIN = 2;
  localparam int LAT_CNT_W = LAT_BITS + 1; // Holds up to LAT_MIN - 1 + 15.

  localparam logic [7:0] LFSR_SEED = 8'b1010_1010;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // One memory word, whole or per byte.
  typedef union packed {
    logic [DATA_W-1:0] word;
    logic [STRB_W-1:0][BYTE_W-1:0] bytes;
  } sram_word_t;

endpackage

// ==== design/axi_lite_if.sv ====
`timescale 1ns/100ps

interface axi_r_if import sram_pkg::*; ();
  logic [ADDR_W-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  modport master (output araddr, arvalid, rready,
                  input  arready, rdata, rresp, rvalid);
  modport slave  (input  araddr, arvalid, rready,
                  output arready, rdata, rresp, rvalid);
endinterface

interface axi_w_if import sram_pkg::*; ();
  logic [ADDR_W-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;

  modport master (output awaddr, awvalid, wdata, wstrb, wvalid, bready,
                  input  awready, wready, bresp, bvalid);
  modport slave  (input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
                  output awready, wready, bresp, bvalid);
endinterface

// ==== design/latency_lfsr.sv ====
`timescale 1ns/100ps

module latency_lfsr import sram_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  output logic [7:0] lat_rand
);

  logic feedback;

  // Taps for x^8 + x^6 + x^5 + x^4 + 1, maximal length.
  assign feedback = lat_rand[7] ^ lat_rand[5] ^ lat_rand[4] ^ lat_rand[3];

  always_ff @(posedge clk) begin
    if (rstn) begin
      lat_rand <= LFSR_SEED;
    end else begin
      lat_rand <= {lat_rand[6:0], feedback}; // Steps every cycle.
    end
  end

endmodule

// ==== design/sram_array.sv ====
`timescale 1ns/100ps

module sram_array import sram_pkg::*; (
  input  logic                      clk,
  input  logic                      mem_ren,
  input  logic [MEM_WORDS_LOG2-1:0] mem_raddr,
  output sram_word_t                mem_rdata,
  input  logic                      mem_wen,
  input  logic [MEM_WORDS_LOG2-1:0] mem_waddr,
  input  sram_word_t                mem_wdata,
  input  logic [STRB_W-1:0]         mem_wstrb
);

  sram_word_t mem [MEM_WORDS];

  // Byte lanes written only where the strobe is set.
  always_ff @(posedge clk) begin
    if (mem_wen) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (mem_wstrb[b]) begin
          mem[mem_waddr].bytes[b] <= mem_wdata.bytes[b];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_ren) begin
      mem_rdata.word <= mem[mem_raddr].word; // Registered read.
    end
  end

endmodule

// ==== design/axi_read_port.sv ====
`timescale 1ns/100ps

module axi_read_port import sram_pkg::*; (
  input  logic                      clk,
  input  logic                      rstn,
  axi_r_if.slave                    rd,
  input  logic [7:0]                lat_rand,
  output logic                      mem_ren,
  output logic [MEM_WORDS_LOG2-1:0] mem_raddr,
  input  sram_word_t                mem_rdata
);

  logic busy;
  logic bad_addr;
  logic [LAT_CNT_W-1:0] cnt;
  logic ar_fire;
  logic r_fire;
  logic expire;

  assign ar_fire = rd.arvalid & rd.arready;
  assign r_fire = rd.rvalid & rd.rready;
  assign expire = busy & (cnt == '0);

  // One outstanding read.
  assign rd.arready = ~busy & ~rd.rvalid;

  // Array read one cycle ahead of R.
  assign mem_ren = busy & (cnt == LAT_CNT_W'(1)) & ~bad_addr;

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy <= 1'b0;
      cnt <= '0;
      rd.rvalid <= 1'b0;
    end else begin
      if (ar_fire) begin
        busy <= 1'b1;
        cnt <= LAT_CNT_W'(LAT_MIN - 1) + LAT_CNT_W'(lat_rand[LAT_BITS-1:0]);
      end else if (expire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - 1'b1;
      end

      if (expire) begin
        rd.rvalid <= 1'b1;
      end else if (r_fire) begin
        rd.rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      mem_raddr <= rd.araddr[MEM_WORDS_LOG2+1:2]; // Byte to word index.
      bad_addr <= |rd.araddr[ADDR_W-1:MEM_WORDS_LOG2+2];
    end
    // Held through back-pressure since nothing else loads it.
    if (expire) begin
      rd.rdata <= bad_addr ? '0 : mem_rdata.word;
      rd.rresp <= bad_addr ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

// ==== design/axi_write_port.sv ====
`timescale 1ns/100ps

module axi_write_port import sram_pkg::*; (
  input  logic                      clk,
  input  logic                      rstn,
  axi_w_if.slave                    wr,
  input  logic [7:0]                lat_rand,
  output logic                      mem_wen,
  output logic [MEM_WORDS_LOG2-1:0] mem_waddr,
  output sram_word_t                mem_wdata,
  output logic [STRB_W-1:0]         mem_wstrb
);

  logic aw_held;
  logic w_held;
  logic busy;
  logic bad_addr;
  logic [LAT_CNT_W-1:0] cnt;
  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic start;
  logic expire;

  assign aw_fire = wr.awvalid & wr.awready;
  assign w_fire = wr.wvalid & wr.wready;
  assign b_fire = wr.bvalid & wr.bready;

  // Each channel closes after its own transfer until B completes.
  assign wr.awready = ~aw_held;
  assign wr.wready = ~w_held;

  // Second half of the pair arrives, or both at once.
  assign start = (aw_fire & (w_fire | w_held)) | (w_fire & aw_held);
  assign expire = busy & (cnt == '0);

  assign mem_wen = expire & ~bad_addr; // Same edge as bvalid.

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_held <= 1'b0;
      w_held <= 1'b0;
      busy <= 1'b0;
      cnt <= '0;
      wr.bvalid <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_held <= 1'b1;
      end else if (b_fire) begin
        aw_held <= 1'b0;
      end

      if (w_fire) begin
        w_held <= 1'b1;
      end else if (b_fire) begin
        w_held <= 1'b0;
      end

      if (start) begin
        busy <= 1'b1;
        cnt <= LAT_CNT_W'(LAT_MIN - 1) + LAT_CNT_W'(lat_rand[LAT_BITS-1:0]);
      end else if (expire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - 1'b1;
      end

      if (expire) begin
        wr.bvalid <= 1'b1;
      end else if (b_fire) begin
        wr.bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      mem_waddr <= wr.awaddr[MEM_WORDS_LOG2+1:2];
      bad_addr <= |wr.awaddr[ADDR_W-1:MEM_WORDS_LOG2+2];
    end
    if (w_fire) begin
      mem_wdata.word <= wr.wdata;
      mem_wstrb <= wr.wstrb;
    end
    if (expire) begin
      wr.bresp <= bad_addr ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

// ==== design/sram_top.sv ====
`timescale 1ns/100ps

module sram_top import sram_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready
);

  logic [7:0] lat_rand;
  logic mem_ren;
  logic [MEM_WORDS_LOG2-1:0] mem_raddr;
  sram_word_t mem_rdata;
  logic mem_wen;
  logic [MEM_WORDS_LOG2-1:0] mem_waddr;
  sram_word_t mem_wdata;
  logic [STRB_W-1:0] mem_wstrb;

  axi_r_if rd_bus ();
  axi_w_if wr_bus ();

  // Master side of both buses comes straight from the pins.
  assign rd_bus.araddr = araddr;
  assign rd_bus.arvalid = arvalid;
  assign rd_bus.rready = rready;
  assign arready = rd_bus.arready;
  assign rdata = rd_bus.rdata;
  assign rresp = rd_bus.rresp;
  assign rvalid = rd_bus.rvalid;

  assign wr_bus.awaddr = awaddr;
  assign wr_bus.awvalid = awvalid;
  assign wr_bus.wdata = wdata;
  assign wr_bus.wstrb = wstrb;
  assign wr_bus.wvalid = wvalid;
  assign wr_bus.bready = bready;
  assign awready = wr_bus.awready;
  assign wready = wr_bus.wready;
  assign bresp = wr_bus.bresp;
  assign bvalid = wr_bus.bvalid;

  latency_lfsr u_lfsr (
    .clk      (clk),
    .rstn     (rstn),
    .lat_rand (lat_rand)
  );

  axi_read_port u_read (
    .clk       (clk),
    .rstn      (rstn),
    .rd        (rd_bus.slave),
    .lat_rand  (lat_rand),
    .mem_ren   (mem_ren),
    .mem_raddr (mem_raddr),
    .mem_rdata (mem_rdata)
  );

  axi_write_port u_write (
    .clk       (clk),
    .rstn      (rstn),
    .wr        (wr_bus.slave),
    .lat_rand  (lat_rand),
    .mem_wen   (mem_wen),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb)
  );

  sram_array u_array (
    .clk       (clk),
    .mem_ren   (mem_ren),
    .mem_raddr (mem_raddr),
    .mem_rdata (mem_rdata),
    .mem_wen   (mem_wen),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  initial begin
    rstn = 1'b1; // Active high.
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
  end

endmodule

// ==== tb/sram_top_properties.sv ====
`timescale 1ns/100ps

module sram_top_properties import sram_pkg::*; (
  input logic              clk,
  input logic              rstn,
  input logic              arready,
  input logic [DATA_W-1:0] rdata,
  input logic [1:0]        rresp,
  input logic              rvalid,
  input logic              rready,
  input logic              awready,
  input logic              wready,
  input logic [1:0]        bresp,
  input logic              bvalid,
  input logic              bready
);

  logic [7:0] r_wait;
  logic [7:0] b_wait;

  // Cycles spent waiting for a response, back-pressure excluded.
  always_ff @(posedge clk) begin
    if (rstn || rvalid) begin
      r_wait <= '0;
    end else if (!arready) begin
      r_wait <= r_wait + 8'd1;
    end
    if (rstn || bvalid) begin
      b_wait <= '0;
    end else if (!awready && !wready) begin
      b_wait <= b_wait + 8'd1; // Both halves of the write held.
    end
  end

  r_hold: assert property (@(posedge clk) disable iff (rstn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("rvalid or read payload changed before the R transfer");

  b_hold: assert property (@(posedge clk) disable iff (rstn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid or bresp changed before the B transfer");

  ar_closed: assert property (@(posedge clk) disable iff (rstn) rvalid |-> !arready)
    else $error("arready high while a read response is pending");

  aw_w_closed: assert property (@(posedge clk) disable iff (rstn)
    bvalid |-> !awready && !wready)
    else $error("awready or wready high while a write response is pending");

  r_latency: assert property (@(posedge clk) disable iff (rstn) r_wait <= LAT_MIN + 15)
    else $error("read response later than the maximum latency");

  b_latency: assert property (@(posedge clk) disable iff (rstn) b_wait <= LAT_MIN + 15)
    else $error("write response later than the maximum latency");

endmodule

// ==== tb/sram_top_tb.sv ====
`timescale 1ns/100ps

module sram_top_tb import sram_pkg::*; ();

  localparam int N_ADDR = 8;
  localparam int N_TXN = 4 * N_ADDR + 6 + 3;
  localparam int TIMEOUT_CYCLES = 40 * N_TXN;

  logic clk;
  logic rstn;
  logic [ADDR_W-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [ADDR_W-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;

  logic [31:0] lfsr_state = 32'h1a40;
  sram_word_t shadow [MEM_WORDS];
  logic [DATA_W-1:0] exp_rdata[$];
  logic [1:0] exp_rresp[$];
  logic [1:0] exp_bresp[$];
  int cycles = 0;

  tb_clock_gen u_clk (.clk(clk), .rstn(rstn));

  sram_top DUT (.*);

  bind sram_top sram_top_properties u_props (.clk, .rstn, .arready, .rdata, .rresp, .rvalid,
    .rready, .awready, .wready, .bresp, .bvalid, .bready);

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic addr_ok(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1:MEM_WORDS_LOG2+2] == '0; // Beyond 4 KiB is out of range.
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                      output logic [1:0] resp);
    resp = addr_ok(addr) ? RESP_OKAY : RESP_SLVERR;
    return addr_ok(addr) ? shadow[addr[MEM_WORDS_LOG2+1:2]].word : '0;
  endfunction

  task automatic shadow_write(input logic [ADDR_W-1:0] addr, input sram_word_t data,
                              input logic [STRB_W-1:0] strb);
    for (int b = 0; b < STRB_W; b++) begin
      if (addr_ok(addr) && strb[b]) begin
        shadow[addr[MEM_WORDS_LOG2+1:2]].bytes[b] = data.bytes[b];
      end
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // Order 0 sends AW first, 1 sends W first, 2 sends both together.
  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input int order);
    logic aw_todo;
    logic w_todo;
    logic aw_go;
    logic w_go;
    int delay;
    exp_bresp.push_back(addr_ok(addr) ? RESP_OKAY : RESP_SLVERR);
    shadow_write(addr, data, strb);
    delay = int'(rand_bits(3));
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    aw_todo = 1'b1;
    w_todo = 1'b1;
    while (aw_todo || w_todo) begin
      awvalid = aw_todo && (order != 1 || !w_todo);
      wvalid = w_todo && (order != 0 || !aw_todo);
      aw_go = awvalid && awready; // Transfer on the next rising edge.
      w_go = wvalid && wready;
      @(negedge clk);
      aw_todo = aw_todo && !aw_go;
      w_todo = w_todo && !w_go;
    end
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge clk);
    repeat (delay) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr);
    logic [1:0] resp;
    int delay;
    exp_rdata.push_back(expected_read(addr, resp));
    exp_rresp.push_back(resp);
    delay = int'(rand_bits(3));
    araddr = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    repeat (delay) @(negedge clk); // Back-pressure.
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Checks every R and B transfer against the queued expectations.
  always @(posedge clk) begin
    if (!rstn && rvalid && rready) begin
      assert (exp_rdata.size() > 0) else fail_run("read response arrived with no read pending");
      assert (rdata === exp_rdata[0] && rresp === exp_rresp[0]) else
        fail_run($sformatf("[FAIL] %0t read data %h resp %0d, expected %h resp %0d",
                           $time, rdata, rresp, exp_rdata[0], exp_rresp[0]));
      void'(exp_rdata.pop_front());
      void'(exp_rresp.pop_front());
    end
    if (!rstn && bvalid && bready) begin
      assert (exp_bresp.size() > 0) else fail_run("write response arrived with no write pending");
      assert (bresp === exp_bresp[0]) else
        fail_run($sformatf("[FAIL] %0t bresp %0d, expected %0d", $time, bresp, exp_bresp[0]));
      void'(exp_bresp.pop_front());
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycles));
    end
  end

  initial begin
    logic [ADDR_W-1:0] addrs [N_ADDR];
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    int order;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    @(posedge clk);
    while (rstn) @(posedge clk); // Reset only moves on falling edges.
    @(negedge clk);
    assert (!rvalid && !bvalid && arready && awready && wready) else
      fail_run($sformatf("[FAIL] %0t handshake outputs wrong after reset", $time));

    for (int i = 0; i < N_ADDR; i++) begin
      addrs[i] = rand_bits(MEM_WORDS_LOG2) << 2;
      data = rand_bits(DATA_W);
      axi_write(addrs[i], data, '1, i % 3);
    end
    for (int i = 0; i < N_ADDR; i++) axi_read(addrs[i]);

    for (int i = 0; i < N_ADDR; i++) begin
      data = rand_bits(DATA_W);
      strb = STRB_W'(rand_bits(STRB_W)); // Partial lanes.
      order = int'(rand_bits(2)) % 3;
      axi_write(addrs[i], data, strb, order);
    end
    for (int i = 0; i < N_ADDR; i++) axi_read(addrs[i]);

    for (int k = 0; k < 3; k++) begin
      data = rand_bits(DATA_W);
      axi_write(addrs[0], data, '1, k);
      axi_read(addrs[0]);
    end

    // Aliases addrs[1] in the low bits.
    data = rand_bits(DATA_W);
    axi_write(addrs[1] | 32'h0010_0000, data, '1, 2);
    axi_read(addrs[1] | 32'h0010_0000);
    axi_read(addrs[1]);

    if (exp_rdata.size() == 0 && exp_bresp.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      fail_run("responses still missing at the end of the run");
    end
  end

endmodule

// ==== vlog.f ====
design/sram_pkg.sv
design/axi_lite_if.sv
design/latency_lfsr.sv
design/sram_array.sv
design/axi_read_port.sv
design/axi_write_port.sv
design/sram_top.sv
tb/tb_clock_gen.sv
tb/sram_top_properties.sv
tb/sram_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sram_top_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
